//--- common/ooo_pkg.sv
// Out-of-order core shared types
`default_nettype none

package ooo_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int DATA_WIDTH  = 16;            // Register and result width
    localparam int NUM_REGS    = 8;             // Architectural registers
    localparam int REG_IDX_W   = 3;
    localparam int ROB_DEPTH   = 8;             // Tag is a ROB index
    localparam int TAG_W       = 3;
    localparam int ROB_CNT_W   = TAG_W + 1;     // Occupancy, 0 to ROB_DEPTH
    localparam int RS_DEPTH    = 4;
    localparam int RS_IDX_W    = 2;
    localparam int MUL_LATENCY = 3;             // Issue to CDB, in cycles

    // Opcodes, already decoded
    typedef enum logic [2:0] {
        OP_LI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL
    } op_e;

    typedef struct packed {
        op_e                   op;
        logic [REG_IDX_W-1:0]  rd;
        logic [REG_IDX_W-1:0]  rs1;
        logic [REG_IDX_W-1:0]  rs2;
        logic [DATA_WIDTH-1:0] imm;             // Only used by OP_LI
    } inst_t;

    // Source operand, either a value or a tag to wait on
    typedef struct packed {
        logic                  ready;
        logic [TAG_W-1:0]      tag;
        logic [DATA_WIDTH-1:0] value;
    } operand_t;

    // RS to functional unit
    typedef struct packed {
        logic                  valid;
        op_e                   op;
        logic [TAG_W-1:0]      tag;             // Destination ROB entry
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
    } issue_t;

    // Common data bus broadcast
    typedef struct packed {
        logic                  valid;
        logic [TAG_W-1:0]      tag;
        logic [DATA_WIDTH-1:0] value;
    } cdb_t;

    // Retired result
    typedef struct packed {
        logic [REG_IDX_W-1:0]  rd;
        logic [DATA_WIDTH-1:0] data;
    } commit_t;

endpackage

`default_nettype wire

//--- hw/issue/dispatch.sv
// Dispatch and tagged register file
`timescale 1ns/1ps
`default_nettype none

module dispatch import ooo_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  inst_t                 inst,
    output logic                  inst_ready,
    input  logic [TAG_W-1:0]      rob_tail_tag,   // Tag for the incoming instruction
    input  logic                  rob_full,
    input  logic                  rs_full,
    input  logic                  lookup_done_a,
    input  logic                  lookup_done_b,
    input  logic [DATA_WIDTH-1:0] lookup_value_a,
    input  logic [DATA_WIDTH-1:0] lookup_value_b,
    input  cdb_t                  cdb,
    input  logic                  commit_valid,
    input  commit_t               commit,
    input  logic [TAG_W-1:0]      commit_tag,
    output logic                  rs_write,
    output op_e                   rs_op,
    output operand_t              rs_src_a,
    output operand_t              rs_src_b,
    output logic [TAG_W-1:0]      rs_tag,
    output logic                  rob_alloc,
    output logic [REG_IDX_W-1:0]  rob_alloc_rd,
    output logic [TAG_W-1:0]      lookup_tag_a,
    output logic [TAG_W-1:0]      lookup_tag_b
);

    logic [DATA_WIDTH-1:0] regs  [NUM_REGS];  // Architectural values
    logic [TAG_W-1:0]      owner [NUM_REGS];  // Youngest in-flight writer
    logic [NUM_REGS-1:0]   busy;
    logic                  accept_en;          // Low during and just after reset
    logic                  accept;

    // Register file, then finished ROB entry, then same-cycle CDB
    function automatic operand_t resolve(
        input logic                  busy_bit,
        input logic [TAG_W-1:0]      owner_tag,
        input logic [DATA_WIDTH-1:0] reg_value,
        input logic                  fwd_done,
        input logic [DATA_WIDTH-1:0] fwd_value,
        input cdb_t                  bus
    );
        operand_t res;
        res.ready = 1'b1;
        res.tag   = owner_tag;
        res.value = reg_value;
        if (busy_bit) begin
            if (fwd_done) begin
                res.value = fwd_value;              // Done in ROB, not yet retired
            end else if (bus.valid && bus.tag == owner_tag) begin
                res.value = bus.value;              // Broadcast this cycle
            end else begin
                res.ready = 1'b0;                   // Wait in the RS
            end
        end
        return res;
    endfunction

    assign inst_ready   = accept_en && !rob_full && !rs_full;
    assign accept       = inst_valid && inst_ready;
    assign rs_write     = accept;
    assign rob_alloc    = accept;
    assign rob_alloc_rd = inst.rd;
    assign rs_op        = inst.op;
    assign rs_tag       = rob_tail_tag;
    assign lookup_tag_a = owner[inst.rs1];
    assign lookup_tag_b = owner[inst.rs2];

    always_comb begin
        rs_src_a = resolve(busy[inst.rs1], owner[inst.rs1], regs[inst.rs1],
                           lookup_done_a, lookup_value_a, cdb);
        rs_src_b = resolve(busy[inst.rs2], owner[inst.rs2], regs[inst.rs2],
                           lookup_done_b, lookup_value_b, cdb);
        if (inst.op == OP_LI) begin
            rs_src_a = '{ready: 1'b1, tag: '0, value: inst.imm};  // Immediate as operand
            rs_src_b = '{ready: 1'b1, tag: '0, value: '0};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            accept_en <= 1'b0;
            busy      <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i]  <= '0;
                owner[i] <= '0;
            end
        end else begin
            accept_en <= 1'b1;
            if (commit_valid) begin
                regs[commit.rd] <= commit.data;
                // Younger writer keeps the register busy
                if (owner[commit.rd] == commit_tag) busy[commit.rd] <= 1'b0;
            end
            if (accept) begin                       // Rename wins over commit
                busy[inst.rd]  <= 1'b1;
                owner[inst.rd] <= rob_tail_tag;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/issue/reservation_station.sv
// Reservation station with CDB wakeup
`timescale 1ns/1ps
`default_nettype none

module reservation_station import ooo_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             rs_write,
    input  op_e              rs_op,
    input  operand_t         rs_src_a,
    input  operand_t         rs_src_b,
    input  logic [TAG_W-1:0] rs_tag,
    input  cdb_t             cdb,
    input  logic             alu_ready,
    output logic             rs_full,
    output issue_t           alu_issue,
    output issue_t           mul_issue
);

    logic [RS_DEPTH-1:0] ent_valid;
    op_e                 ent_op  [RS_DEPTH];
    logic [TAG_W-1:0]    ent_tag [RS_DEPTH];
    operand_t            ent_a   [RS_DEPTH];
    operand_t            ent_b   [RS_DEPTH];

    logic                alu_hit;
    logic                mul_hit;
    logic [RS_IDX_W-1:0] alu_idx;
    logic [RS_IDX_W-1:0] mul_idx;
    logic [RS_IDX_W-1:0] free_idx;

    // Capture a broadcast into a waiting operand
    function automatic operand_t wake(input operand_t src, input cdb_t bus);
        operand_t res;
        res = src;
        if (!src.ready && bus.valid && bus.tag == src.tag) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    assign rs_full = &ent_valid;

    ////////////////////////////////////////
    // Select, lowest index wins
    ////////////////////////////////////////
    always_comb begin
        alu_hit  = 1'b0;
        mul_hit  = 1'b0;
        alu_idx  = '0;
        mul_idx  = '0;
        free_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin  // Descending, last hit is lowest
            if (!ent_valid[i]) free_idx = RS_IDX_W'(i);
            if (ent_valid[i] && ent_a[i].ready && ent_b[i].ready) begin
                if (ent_op[i] == OP_MUL) begin
                    mul_hit = 1'b1;
                    mul_idx = RS_IDX_W'(i);
                end else begin
                    alu_hit = 1'b1;
                    alu_idx = RS_IDX_W'(i);
                end
            end
        end
    end

    always_comb begin
        alu_issue = '{valid: alu_hit && alu_ready, op: ent_op[alu_idx], tag: ent_tag[alu_idx],
                      a: ent_a[alu_idx].value, b: ent_b[alu_idx].value};
        mul_issue = '{valid: mul_hit, op: ent_op[mul_idx], tag: ent_tag[mul_idx],
                      a: ent_a[mul_idx].value, b: ent_b[mul_idx].value};  // Never stalls
    end

    // Occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            ent_valid <= '0;
        end else begin
            if (alu_issue.valid) ent_valid[alu_idx] <= 1'b0;   // Freed on issue
            if (mul_issue.valid) ent_valid[mul_idx] <= 1'b0;
            if (rs_write)        ent_valid[free_idx] <= 1'b1;  // Free slot, never an issuer
        end
    end

    // Entry contents and wakeup
    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ent_a[i] <= wake(ent_a[i], cdb);
            ent_b[i] <= wake(ent_b[i], cdb);
        end
        if (rs_write) begin
            ent_op[free_idx]  <= rs_op;
            ent_tag[free_idx] <= rs_tag;
            ent_a[free_idx]   <= rs_src_a;           // Already CDB-forwarded by dispatch
            ent_b[free_idx]   <= rs_src_b;
        end
    end

endmodule

`default_nettype wire

//--- hw/execute/exec_units.sv
// ALU, pipelined multiplier and CDB
`timescale 1ns/1ps
`default_nettype none

module exec_units import ooo_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  issue_t alu_issue,
    input  issue_t mul_issue,
    output logic   alu_ready,
    output cdb_t   cdb
);

    cdb_t alu_res;                  // Held ALU result, valid while pending
    cdb_t mul_stage [MUL_LATENCY];  // Multiplier pipeline
    cdb_t mul_out;

    function automatic logic [DATA_WIDTH-1:0] alu_op(
        input op_e                   op,
        input logic [DATA_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] b
    );
        logic [DATA_WIDTH-1:0] res;
        case (op)
            OP_ADD:  res = a + b;   // Wraps at DATA_WIDTH
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            default: res = a;       // OP_LI passes the immediate
        endcase
        return res;
    endfunction

    assign mul_out = mul_stage[MUL_LATENCY-1];

    ////////////////////////////////////////
    // CDB arbitration
    ////////////////////////////////////////
    assign cdb       = mul_out.valid ? mul_out : alu_res;  // Multiplier has priority
    assign alu_ready = !alu_res.valid || !mul_out.valid;   // Held result drains this cycle

    // ALU, one result register
    always_ff @(posedge clock) begin
        if (reset) begin
            alu_res.valid <= 1'b0;
        end else if (alu_issue.valid) begin
            alu_res.valid <= 1'b1;
            alu_res.tag   <= alu_issue.tag;
            alu_res.value <= alu_op(alu_issue.op, alu_issue.a, alu_issue.b);
        end else if (alu_res.valid && !mul_out.valid) begin
            alu_res.valid <= 1'b0;                  // Broadcast went out
        end
    end

    // Multiplier, low half of the product
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MUL_LATENCY; i++) begin
                mul_stage[i].valid <= 1'b0;
            end
        end else begin
            mul_stage[0].valid <= mul_issue.valid;
            mul_stage[0].tag   <= mul_issue.tag;
            mul_stage[0].value <= mul_issue.a * mul_issue.b;  // Truncated to DATA_WIDTH
            for (int i = 1; i < MUL_LATENCY; i++) begin
                mul_stage[i] <= mul_stage[i-1];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/retire/reorder_buffer.sv
// Reorder buffer with in-order retirement
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  rob_alloc,
    input  logic [REG_IDX_W-1:0]  rob_alloc_rd,
    input  cdb_t                  cdb,
    input  logic [TAG_W-1:0]      lookup_tag_a,
    input  logic [TAG_W-1:0]      lookup_tag_b,
    output logic [TAG_W-1:0]      rob_tail_tag,
    output logic                  rob_full,
    output logic                  lookup_done_a,
    output logic                  lookup_done_b,
    output logic [DATA_WIDTH-1:0] lookup_value_a,
    output logic [DATA_WIDTH-1:0] lookup_value_b,
    output logic                  commit_valid,
    output commit_t               commit,
    output logic [TAG_W-1:0]      commit_tag
);

    logic [TAG_W-1:0]      head;    // Oldest entry
    logic [TAG_W-1:0]      tail;    // Next free entry
    logic [ROB_CNT_W-1:0]  count;
    logic [ROB_DEPTH-1:0]  done;
    logic [REG_IDX_W-1:0]  ent_rd    [ROB_DEPTH];
    logic [DATA_WIDTH-1:0] ent_value [ROB_DEPTH];

    assign rob_tail_tag = tail;
    assign rob_full     = (count == ROB_CNT_W'(ROB_DEPTH));

    // Head retires once done, one per cycle
    assign commit_valid = (count != '0) && done[head];
    assign commit_tag   = head;
    assign commit       = '{rd: ent_rd[head], data: ent_value[head]};

    // Forwarding reads for dispatch
    assign lookup_done_a  = done[lookup_tag_a];
    assign lookup_done_b  = done[lookup_tag_b];
    assign lookup_value_a = ent_value[lookup_tag_a];
    assign lookup_value_b = ent_value[lookup_tag_b];

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (cdb.valid) done[cdb.tag] <= 1'b1;
            if (rob_alloc) begin
                done[tail] <= 1'b0;                 // Never the broadcast tag
                tail       <= tail + 1'b1;          // Wraps, depth is a power of two
            end
            if (commit_valid) head <= head + 1'b1;
            case ({rob_alloc, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rob_alloc) ent_rd[tail]     <= rob_alloc_rd;
        if (cdb.valid) ent_value[cdb.tag] <= cdb.value;
    end

endmodule

`default_nettype wire

//--- hw/ooo_core.sv
// Out-of-order core top level
`timescale 1ns/1ps
`default_nettype none

module ooo_core import ooo_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    inst_valid,
    input  inst_t   inst,
    output logic    inst_ready,
    output logic    commit_valid,
    output commit_t commit
);

    // Dispatch to RS and ROB
    logic                  rs_write;
    op_e                   rs_op;
    operand_t              rs_src_a;
    operand_t              rs_src_b;
    logic [TAG_W-1:0]      rs_tag;
    logic                  rs_full;
    logic                  rob_alloc;
    logic [REG_IDX_W-1:0]  rob_alloc_rd;
    logic [TAG_W-1:0]      rob_tail_tag;
    logic                  rob_full;

    // ROB forwarding reads
    logic [TAG_W-1:0]      lookup_tag_a;
    logic [TAG_W-1:0]      lookup_tag_b;
    logic                  lookup_done_a;
    logic                  lookup_done_b;
    logic [DATA_WIDTH-1:0] lookup_value_a;
    logic [DATA_WIDTH-1:0] lookup_value_b;

    // Issue, execute and retire
    issue_t                alu_issue;
    issue_t                mul_issue;
    logic                  alu_ready;
    cdb_t                  cdb;
    logic [TAG_W-1:0]      commit_tag;

    dispatch u_dispatch (
        .clock          (clock),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_ready     (inst_ready),
        .rob_tail_tag   (rob_tail_tag),
        .rob_full       (rob_full),
        .rs_full        (rs_full),
        .lookup_done_a  (lookup_done_a),
        .lookup_done_b  (lookup_done_b),
        .lookup_value_a (lookup_value_a),
        .lookup_value_b (lookup_value_b),
        .cdb            (cdb),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .commit_tag     (commit_tag),
        .rs_write       (rs_write),
        .rs_op          (rs_op),
        .rs_src_a       (rs_src_a),
        .rs_src_b       (rs_src_b),
        .rs_tag         (rs_tag),
        .rob_alloc      (rob_alloc),
        .rob_alloc_rd   (rob_alloc_rd),
        .lookup_tag_a   (lookup_tag_a),
        .lookup_tag_b   (lookup_tag_b)
    );

    reservation_station u_rs (
        .clock     (clock),
        .reset     (reset),
        .rs_write  (rs_write),
        .rs_op     (rs_op),
        .rs_src_a  (rs_src_a),
        .rs_src_b  (rs_src_b),
        .rs_tag    (rs_tag),
        .cdb       (cdb),
        .alu_ready (alu_ready),
        .rs_full   (rs_full),
        .alu_issue (alu_issue),
        .mul_issue (mul_issue)
    );

    exec_units u_exec (
        .clock     (clock),
        .reset     (reset),
        .alu_issue (alu_issue),
        .mul_issue (mul_issue),
        .alu_ready (alu_ready),
        .cdb       (cdb)
    );

    reorder_buffer u_rob (
        .clock          (clock),
        .reset          (reset),
        .rob_alloc      (rob_alloc),
        .rob_alloc_rd   (rob_alloc_rd),
        .cdb            (cdb),
        .lookup_tag_a   (lookup_tag_a),
        .lookup_tag_b   (lookup_tag_b),
        .rob_tail_tag   (rob_tail_tag),
        .rob_full       (rob_full),
        .lookup_done_a  (lookup_done_a),
        .lookup_done_b  (lookup_done_b),
        .lookup_value_a (lookup_value_a),
        .lookup_value_b (lookup_value_b),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .commit_tag     (commit_tag)
    );

endmodule

`default_nettype wire

//--- test/ooo_core_props.sv
// Reorder buffer and CDB assertions
`timescale 1ns/1ps
`default_nettype none

module ooo_core_props import ooo_pkg::*; (
    input logic                 clock,
    input logic                 reset,
    input logic                 rob_alloc,
    input logic                 rob_full,
    input logic                 commit_valid,
    input cdb_t                 cdb,
    input logic [TAG_W-1:0]     head,
    input logic [ROB_CNT_W-1:0] count
);

    logic [TAG_W-1:0]     cdb_age;
    logic [ROB_CNT_W-1:0] live;          // Allocations minus commits seen here

    assign cdb_age = cdb.tag - head;     // Distance from the oldest entry

    // Occupancy rebuilt from the alloc and commit events
    always_ff @(posedge clock) begin
        if (reset) begin
            live <= '0;
        end else begin
            live <= live + ROB_CNT_W'(rob_alloc) - ROB_CNT_W'(commit_valid);
        end
    end

    a_commit_nonempty: assert property (@(posedge clock) disable iff (reset)
        commit_valid |-> live != '0)
        else $error("commit_valid raised with an empty reorder buffer");

    a_no_alloc_when_full: assert property (@(posedge clock) disable iff (reset)
        !(rob_full && rob_alloc))
        else $error("reorder buffer allocated while full");

    // Live entries sit between head and head + count
    a_cdb_live_tag: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> ROB_CNT_W'(cdb_age) < count)
        else $error("CDB broadcast for tag %0d which is not allocated", cdb.tag);

endmodule

bind reorder_buffer ooo_core_props u_props (
    .clock        (clock),
    .reset        (reset),
    .rob_alloc    (rob_alloc),
    .rob_full     (rob_full),
    .commit_valid (commit_valid),
    .cdb          (cdb),
    .head         (head),
    .count        (count)
);

`default_nettype wire

//--- test/commit_checker.sv
// Commit checker with in-order model
`timescale 1ns/1ps
`default_nettype none

module commit_checker import ooo_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    inst_valid,
    input  logic    inst_ready,
    input  inst_t   inst,
    input  logic    commit_valid,
    input  commit_t commit,
    output int      outstanding          // Accepted but not yet retired
);

    logic [DATA_WIDTH-1:0] model_regs [NUM_REGS] = '{default: '0};
    commit_t               expect_q [$];      // Expected commits, program order
    logic                  reset_d = 1'b0;

    // Per-test and run totals
    string cur_test      = "reset";
    int    test_accepts  = 0;
    int    test_commits  = 0;
    int    test_stalls   = 0;
    int    test_errors   = 0;
    int    tests_run     = 0;
    int    tests_failed  = 0;
    int    total_commits = 0;
    int    total_errors  = 0;

    // Sequential reference, one instruction at a time
    function automatic logic [DATA_WIDTH-1:0] model_exec(
        input inst_t                 x,
        input logic [DATA_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] b
    );
        logic [2*DATA_WIDTH-1:0] prod;
        logic [DATA_WIDTH-1:0]   res;
        prod = {{DATA_WIDTH{1'b0}}, a} * {{DATA_WIDTH{1'b0}}, b};  // Full product
        case (x.op)
            OP_LI:   res = x.imm;
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_MUL:  res = prod[DATA_WIDTH-1:0];   // Low half only
            default: res = 'x;
        endcase
        return res;
    endfunction

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic begin_test(input string name);
        cur_test     = name;
        test_accepts = 0;
        test_commits = 0;
        test_stalls  = 0;
        test_errors  = 0;
    endtask

    // One summary line per test
    task automatic end_test(input bit need_stall);
        if (expect_q.size() != 0) begin
            $display("Test %s: %0d accepted instructions were never committed",
                     cur_test, expect_q.size());
            note_error();
        end
        if (test_commits != test_accepts) begin
            $display("Test %s: %0d accepted but %0d committed",
                     cur_test, test_accepts, test_commits);
            note_error();
        end
        if (need_stall && test_stalls == 0) begin
            $display("Test %s: inst_ready never dropped during the burst", cur_test);
            note_error();
        end
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("Test %s: %0d accepted, %0d committed, %0d stall cycles, %0d errors, %s",
                 cur_test, test_accepts, test_commits, test_stalls, test_errors,
                 (test_errors == 0) ? "ok" : "failed");
    endtask

    ////////////////////////////////////////
    // Handshake and commit monitor
    ////////////////////////////////////////
    always @(posedge clock) begin
        commit_t               exp_c;
        logic [DATA_WIDTH-1:0] result;
        if (reset_d) begin                       // Registers have seen reset
            if (inst_ready !== 1'b0) begin
                $display("** Error [%s] inst_ready at reset: expected 0, actual %b",
                         cur_test, inst_ready);
                note_error();
            end
            if (commit_valid !== 1'b0) begin
                $display("** Error [%s] commit_valid at reset: expected 0, actual %b",
                         cur_test, commit_valid);
                note_error();
            end
        end
        if (!reset) begin
            if (inst_valid && !inst_ready) test_stalls++;
            if (commit_valid) begin
                if (expect_q.size() == 0) begin
                    $display("Test %s: commit to r%0d with nothing outstanding",
                             cur_test, commit.rd);
                    note_error();
                end else begin
                    exp_c = expect_q.pop_front();
                    if (commit !== exp_c) begin
                        $display("** Error [%s] commit %0d: expected r%0d=0x%04h, actual r%0d=0x%04h",
                                 cur_test, test_commits, exp_c.rd, exp_c.data,
                                 commit.rd, commit.data);
                        note_error();
                    end
                end
                test_commits++;
                total_commits++;
            end
            if (inst_valid && inst_ready) begin  // Accept edge
                result = model_exec(inst, model_regs[inst.rs1], model_regs[inst.rs2]);
                model_regs[inst.rd] = result;
                expect_q.push_back('{rd: inst.rd, data: result});
                test_accepts++;
            end
        end
        reset_d     <= reset;
        outstanding = expect_q.size();
    end

endmodule

`default_nettype wire

//--- test/tb_ooo_core.sv
// Out-of-order core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core import ooo_pkg::*; ();

    localparam int SEED         = 59199;
    localparam int CLK_HALF     = 10;     // 20 ns period
    localparam int RESET_CYCLES = 16;

    // Phase lengths in instructions
    localparam int N_ZERO  = 8;
    localparam int N_LI    = 40;
    localparam int N_ALU   = 60;
    localparam int N_MIX   = 60;
    localparam int N_BURST = 40;
    localparam int TOTAL_INSTS    = N_ZERO + N_LI + N_ALU + N_MIX + N_BURST;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES
                                  + TOTAL_INSTS * (MUL_LATENCY + ROB_DEPTH + 4) + 200;
    localparam int DRAIN_CYCLES   = ROB_DEPTH * (MUL_LATENCY + ROB_DEPTH + 4);

    // Instruction mixes
    localparam int K_ZERO  = 0;           // Reads of never-written registers
    localparam int K_LI    = 1;
    localparam int K_ALU   = 2;           // Dense reuse of r0..r3
    localparam int K_MIX   = 3;
    localparam int K_BURST = 4;           // Multiply chains on r0..r1

    logic    clock = 1'b0;
    logic    reset;
    logic    inst_valid;
    inst_t   inst;
    logic    inst_ready;
    logic    commit_valid;
    commit_t commit;
    int      outstanding;
    int      cycle_count = 0;

    always #CLK_HALF clock = ~clock;

    ooo_core u_dut (
        .clock        (clock),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_ready   (inst_ready),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    commit_checker u_checker (
        .clock        (clock),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .inst         (inst),
        .commit_valid (commit_valid),
        .commit       (commit),
        .outstanding  (outstanding)
    );

    function automatic logic [REG_IDX_W-1:0] pick_reg(input int span);
        return REG_IDX_W'($urandom % span);
    endfunction

    function automatic op_e pick_alu_op();
        return op_e'(int'(OP_ADD) + int'($urandom % 5));   // ADD through XOR
    endfunction

    function automatic inst_t make_inst(input int kind, input int idx);
        inst_t x;
        int    roll;
        int    span;
        x    = '0;
        roll = int'($urandom % 100);
        span = (kind == K_ALU) ? 4 : (kind == K_BURST) ? 2 : NUM_REGS;
        x.rd  = pick_reg(span);
        x.rs1 = pick_reg(span);
        x.rs2 = pick_reg(span);
        x.imm = DATA_WIDTH'($urandom);
        case (kind)
            K_ZERO: begin
                x.op  = OP_OR;
                x.rd  = REG_IDX_W'(idx);
                x.rs1 = REG_IDX_W'(idx);
                x.rs2 = REG_IDX_W'(idx + 1);  // Not written yet
            end
            K_LI:    x.op = OP_LI;
            K_ALU:   x.op = (roll < 20) ? OP_LI : pick_alu_op();
            K_MIX:   x.op = (roll < 50) ? OP_MUL : (roll < 85) ? pick_alu_op() : OP_LI;
            default: x.op = (roll < 85) ? OP_MUL : OP_LI;
        endcase
        return x;
    endfunction

    ////////////////////////////////////////
    // Stimulus driven on the falling edge
    ////////////////////////////////////////
    task automatic send_inst(input inst_t x, input int gap_max);
        int gap;
        bit taken;
        gap   = int'($urandom % (gap_max + 1));
        taken = 1'b0;
        repeat (gap) begin
            @(negedge clock);
            inst_valid = 1'b0;
        end
        while (!taken) begin
            @(negedge clock);
            inst_valid = 1'b1;
            inst       = x;
            taken      = inst_ready;   // Held until the next rising edge
        end
    endtask

    // Random phase then drain until every accepted instruction retired
    task automatic run_phase(input int kind, input int count, input int gap_max);
        inst_t x;
        int    waited;
        for (int i = 0; i < count; i++) begin
            x = make_inst(kind, i);
            send_inst(x, gap_max);
        end
        @(negedge clock);
        inst_valid = 1'b0;
        waited     = 0;
        while (outstanding != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clock);
            waited++;
        end
        repeat (4) @(negedge clock);           // Catch late duplicates
        u_checker.end_test(kind == K_BURST);
    endtask

    initial begin
        void'($urandom(SEED));
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        u_checker.begin_test("reset");
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        run_phase(K_ZERO, N_ZERO, 1);
        u_checker.begin_test("load_imm");
        run_phase(K_LI, N_LI, 3);
        u_checker.begin_test("alu_chain");
        run_phase(K_ALU, N_ALU, 2);
        u_checker.begin_test("mul_mix");
        run_phase(K_MIX, N_MIX, 2);
        u_checker.begin_test("backpressure");
        run_phase(K_BURST, N_BURST, 0);
        $display("Summary: %0d tests, %0d failed, %0d commits, %0d errors",
                 u_checker.tests_run, u_checker.tests_failed,
                 u_checker.total_commits, u_checker.total_errors);
        if (u_checker.total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Run limit from the total instruction count
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d instructions still in flight",
                     cycle_count, outstanding);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
common/ooo_pkg.sv
hw/issue/dispatch.sv
hw/issue/reservation_station.sv
hw/execute/exec_units.sv
hw/retire/reorder_buffer.sv
hw/ooo_core.sv
test/ooo_core_props.sv
test/commit_checker.sv
test/tb_ooo_core.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_ooo_core
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ_DIR)
LINTFLAGS  := --lint-only --timing --top-module $(TOP)

.PHONY: all build lint clean

all: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
